// File: verilog.f
+incdir+hw
hw/smc_pkg.sv
hw/smc_apb_regs.sv
hw/smc_convert_pipe.sv
hw/smc_result_queue.sv
hw/smc_top.sv
verification/tb_clock_gen.sv
verification/tb_smc_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_smc_top

out=$(./obj_dir/Vtb_smc_top || true)
echo "$out"

if echo "$out" | grep -q "^Test OK$"; then
    exit 0
else
    exit 1
fi

// File: verification/tb_smc_top.sv
// self-checking testbench for smc_top; all APB tasks start and end 1 ns after a rising edge
`timescale 1ns/1ps
`include "smc_consts.svh"

module tb_smc_top;

    localparam int W = `SMC_WIDTH;
    localparam int DEPTH = `SMC_QUEUE_DEPTH;
    localparam int POLL_LIMIT = 50;

    logic          clk;
    logic          rst_n;
    logic          psel;
    logic          penable;
    logic          pwrite;
    logic [7:0]    paddr;
    logic [31:0]   pwdata;
    logic [31:0]   prdata;
    logic          pready;
    logic          pslverr;

    logic [31:0]   lfsr;
    logic [W-1:0]  exp_q [$];

    tb_clock_gen #(.PERIOD_NS(100)) u_clk (.clk(clk));

    smc_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////
    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [7:0] reg_addr(input smc_pkg::reg_sel_t s);
        return {4'b0000, s, 2'b00};
    endfunction

    // signed value to sign and magnitude, most negative gives negative zero
    function automatic logic [W-1:0] model_tc_to_sm(input logic [W-1:0] x);
        longint half;
        longint v;
        longint mag;
        longint r;
        half = longint'(1) << (W - 1);
        v    = longint'(x);
        if (x[W-1]) begin
            v = v - 2 * half;
        end
        mag = (v < 0) ? -v : v;
        r   = mag % half;
        if (x[W-1]) begin
            r = r + half;
        end
        return r[W-1:0];
    endfunction

    function automatic logic [W-1:0] model_sm_to_tc(input logic [W-1:0] x);
        longint full;
        longint mag;
        longint r;
        full = longint'(1) << W;
        mag  = longint'(x[W-2:0]);
        r    = x[W-1] ? (full - mag) % full : mag;
        return r[W-1:0];
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err, input string name);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        compare({name, " pready"}, 32'd1, 32'(pready));
        compare({name, " pslverr"}, 32'(exp_err), 32'(pslverr));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic exp_err,
                            input string name, output logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        compare({name, " pready"}, 32'd1, 32'(pready));
        compare({name, " pslverr"}, 32'(exp_err), 32'(pslverr));
        data = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_op(input smc_pkg::conv_op_t op, input string name);
        logic [31:0] d;
        d = '0;
        d[`SMC_CTRL_OP_BIT] = op;
        apb_write(reg_addr(smc_pkg::REG_CTRL), d, 1'b0, name);
    endtask

    // model entry follows the opcode in force at the write
    task automatic send_sample(input logic [W-1:0] x, input smc_pkg::conv_op_t op,
                               input string name);
        if (op == smc_pkg::OP_TC_TO_SM) begin
            exp_q.push_back(model_tc_to_sm(x));
        end else begin
            exp_q.push_back(model_sm_to_tc(x));
        end
        apb_write(reg_addr(smc_pkg::REG_DATA_IN), 32'(x), 1'b0, name);
    endtask

    task automatic read_status(input string name, output logic [31:0] st);
        apb_read(reg_addr(smc_pkg::REG_STATUS), 1'b0, name, st);
    endtask

    task automatic drain_one(input string name);
        logic [31:0] st;
        logic [31:0] d;
        int          polls;
        polls = 0;
        st    = '0;
        while (st[`SMC_STAT_COUNT_MSB:`SMC_STAT_COUNT_LSB] == '0) begin
            if (polls == POLL_LIMIT) begin
                abort({name, ": timed out waiting for a result in the queue"});
            end
            read_status(name, st);
            polls++;
        end
        if (exp_q.size() == 0) begin
            abort({name, ": result present but the model expects none"});
        end
        apb_read(reg_addr(smc_pkg::REG_RESULT), 1'b0, name, d);
        compare(name, 32'(exp_q.pop_front()), d);
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        logic [31:0] st;
        logic [31:0] st_before;
        logic [31:0] d;
        logic [W-1:0] x;
        lfsr    = 32'h1285_a5e7;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // tc_to_sm, first sample is the most negative value
        set_op(smc_pkg::OP_TC_TO_SM, "tc_to_sm");
        for (int i = 0; i < 40; i++) begin
            x = (i == 0) ? {1'b1, {(W-1){1'b0}}} : W'(take_bits(W));
            send_sample(x, smc_pkg::OP_TC_TO_SM, "tc_to_sm");
            drain_one("tc_to_sm");
        end

        // sm_to_tc, direction flips while items are in flight
        for (int b = 0; b < 10; b++) begin
            set_op(smc_pkg::OP_SM_TO_TC, "sm_to_tc");
            x = (b == 0) ? {1'b1, {(W-1){1'b0}}} : W'(take_bits(W));
            send_sample(x, smc_pkg::OP_SM_TO_TC, "sm_to_tc");
            send_sample(W'(take_bits(W)), smc_pkg::OP_SM_TO_TC, "sm_to_tc");
            set_op(smc_pkg::OP_TC_TO_SM, "sm_to_tc");
            send_sample(W'(take_bits(W)), smc_pkg::OP_TC_TO_SM, "sm_to_tc");
            repeat (3) drain_one("sm_to_tc");
        end

        // back_pressure
        for (int i = 0; i < DEPTH + 2; i++) begin
            x = W'(take_bits(W));
            if (i < DEPTH) begin
                send_sample(x, smc_pkg::OP_TC_TO_SM, "back_pressure");
            end else begin
                apb_write(reg_addr(smc_pkg::REG_DATA_IN), 32'(x), 1'b1, "back_pressure");
            end
        end
        read_status("back_pressure", st);
        compare("back_pressure full", 32'd1, 32'(st[`SMC_STAT_FULL_BIT]));
        compare("back_pressure drop", 32'd1, 32'(st[`SMC_STAT_DROP_BIT]));
        repeat (DEPTH) drain_one("back_pressure");

        // empty_read
        apb_read(reg_addr(smc_pkg::REG_RESULT), 1'b1, "empty_read", d);
        read_status("empty_read", st);
        compare("empty_read empty", 32'd1, 32'(st[`SMC_STAT_EMPTY_BIT]));

        // flush, drop flag is still set from back_pressure
        for (int i = 0; i < 3; i++) begin
            apb_write(reg_addr(smc_pkg::REG_DATA_IN), take_bits(W), 1'b0, "flush");
        end
        d = '0;
        d[`SMC_CTRL_FLUSH_BIT] = 1'b1;
        apb_write(reg_addr(smc_pkg::REG_CTRL), d, 1'b0, "flush");
        st = '0;
        for (int p = 0; p < 4; p++) begin
            read_status("flush", st);
        end
        compare("flush count", 32'd0,
                32'(st[`SMC_STAT_COUNT_MSB:`SMC_STAT_COUNT_LSB]));
        compare("flush empty", 32'd1, 32'(st[`SMC_STAT_EMPTY_BIT]));
        compare("flush drop", 32'd0, 32'(st[`SMC_STAT_DROP_BIT]));
        for (int i = 0; i < 4; i++) begin
            send_sample(W'(take_bits(W)), smc_pkg::OP_TC_TO_SM, "flush");
            drain_one("flush");
        end

        // bad_access
        read_status("bad_access", st_before);
        apb_read(8'h10, 1'b1, "bad_access", d);
        apb_write(reg_addr(smc_pkg::REG_STATUS), 32'hFFFF_FFFF, 1'b1, "bad_access");
        read_status("bad_access", st);
        compare("bad_access status", st_before, st);

        if (exp_q.size() != 0) begin
            $display("model still holds %0d results never read back", exp_q.size());
            $display("Test FAILED");
            $fatal(1);
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: verification/tb_clock_gen.sv
// free-running testbench clock starting low; period given in ns, default 100
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: hw/smc_top.sv
// converter subsystem top; one clock domain, APB with pready always high
`timescale 1ns/1ps
`include "smc_consts.svh"

module smc_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  logic [7:0]    paddr,
    input  logic [31:0]   pwdata,
    output logic [31:0]   prdata,
    output logic          pready,
    output logic          pslverr
);

    localparam int WIDTH = `SMC_WIDTH;

    logic                 start;
    logic                 flush;
    logic [WIDTH-1:0]     sample;
    smc_pkg::conv_op_t    op;
    logic                 pop;
    logic                 space;
    logic                 empty;
    logic [3:0]           count;
    logic [WIDTH-1:0]     head;
    logic                 res_valid;
    logic [WIDTH-1:0]     res_data;

    smc_apb_regs #(.WIDTH(WIDTH)) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .start    (start),
        .flush    (flush),
        .sample   (sample),
        .op       (op),
        .pop      (pop),
        .space    (space),
        .empty    (empty),
        .count    (count),
        .head     (head)
    );

    smc_convert_pipe #(.WIDTH(WIDTH)) u_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .start     (start),
        .sample    (sample),
        .op        (op),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    // reserve is the same pulse as start
    smc_result_queue #(.WIDTH(WIDTH), .DEPTH(`SMC_QUEUE_DEPTH)) u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .reserve   (start),
        .res_valid (res_valid),
        .res_data  (res_data),
        .pop       (pop),
        .space     (space),
        .empty     (empty),
        .count     (count),
        .head      (head)
    );

endmodule

// File: hw/smc_result_queue.sv
// result FIFO counting stored plus reserved slots; pop and reserve are trusted to be legal
`timescale 1ns/1ps
`include "smc_consts.svh"

module smc_result_queue #(
    parameter int WIDTH = `SMC_WIDTH,
    parameter int DEPTH = `SMC_QUEUE_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   reserve,
    input  logic                   res_valid,
    input  logic [WIDTH-1:0]       res_data,
    input  logic                   pop,
    output logic                   space,
    output logic                   empty,
    output logic [3:0]             count,
    output logic [WIDTH-1:0]       head
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     stored;
    logic [CNT_W-1:0]     resv;
    logic [CNT_W:0]       used;

    // a write moves one slot from reserved to stored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            stored <= '0;
            resv   <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            stored <= '0;
            resv   <= '0;
        end else begin
            if (res_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            stored <= stored + CNT_W'(res_valid) - CNT_W'(pop);
            resv   <= resv + CNT_W'(reserve) - CNT_W'(res_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && !flush) begin
            mem[wr_ptr] <= res_data;
        end
    end

    assign used  = {1'b0, stored} + {1'b0, resv};
    assign space = (used < (CNT_W+1)'(DEPTH));
    assign empty = (stored == '0);
    assign count = 4'(stored);
    assign head  = mem[rd_ptr];

endmodule

// File: hw/smc_convert_pipe.sv
// fixed three-cycle converter, no stall; flush is synchronous and drops every item in flight
`timescale 1ns/1ps
`include "smc_consts.svh"

module smc_convert_pipe #(
    parameter int WIDTH = `SMC_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   start,
    input  logic [WIDTH-1:0]       sample,
    input  smc_pkg::conv_op_t      op,
    output logic                   res_valid,
    output logic [WIDTH-1:0]       res_data
);

    logic                 v1;
    logic                 v2;
    logic                 v3;
    logic                 sign1;
    logic [WIDTH-2:0]     low1;
    smc_pkg::conv_op_t    op1;
    logic [WIDTH-2:0]     tc_mag;
    logic [WIDTH-1:0]     sm_val;
    logic [WIDTH-1:0]     mag_next;
    logic                 sign2;
    smc_pkg::conv_op_t    op2;
    logic [WIDTH-1:0]     mag2;
    logic [WIDTH-1:0]     word3;

    // valid chain, cleared by flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else if (flush) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= start;
            v2 <= v1;
            v3 <= v2;
        end
    end

    //////////////////////////////
    // stage 1
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (start) begin
            sign1 <= sample[WIDTH-1];
            low1  <= sample[WIDTH-2:0];
            op1   <= op;
        end
    end

    //////////////////////////////
    // stage 2
    //////////////////////////////
    // most negative input wraps to magnitude zero
    assign tc_mag   = sign1 ? (~low1 + 1'b1) : low1;
    // negative zero comes out as plain zero
    assign sm_val   = sign1 ? (~{1'b0, low1} + 1'b1) : {1'b0, low1};
    assign mag_next = (op1 == smc_pkg::OP_TC_TO_SM) ? {1'b0, tc_mag} : sm_val;

    always_ff @(posedge clk) begin
        sign2 <= sign1;
        op2   <= op1;
        mag2  <= mag_next;
    end

    //////////////////////////////
    // stage 3
    //////////////////////////////
    always_ff @(posedge clk) begin
        word3 <= (op2 == smc_pkg::OP_TC_TO_SM) ? {sign2, mag2[WIDTH-2:0]} : mag2;
    end

    assign res_valid = v3;
    assign res_data  = word3;

endmodule

// File: hw/smc_apb_regs.sv
// APB slave with no wait states; only word-aligned accesses to the four registers are accepted
`timescale 1ns/1ps
`include "smc_consts.svh"

module smc_apb_regs #(
    parameter int WIDTH = `SMC_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   start,
    output logic                   flush,
    output logic [WIDTH-1:0]       sample,
    output smc_pkg::conv_op_t      op,
    output logic                   pop,
    input  logic                   space,
    input  logic                   empty,
    input  logic [3:0]             count,
    input  logic [WIDTH-1:0]       head
);

    logic                 access;
    logic                 addr_ok;
    smc_pkg::reg_sel_t    sel;
    logic                 wr_acc;
    logic                 rd_acc;
    logic                 data_wr;
    logic                 result_rd;
    logic                 refuse;
    logic                 ro_write;
    logic                 ctrl_wr;
    smc_pkg::conv_op_t    op_q;
    logic                 drop_q;
    logic [31:0]          rd_word;

    //////////////////////////////
    // decode
    //////////////////////////////
    assign access  = psel & penable;
    assign addr_ok = (paddr == `SMC_ADDR_CTRL)   || (paddr == `SMC_ADDR_DATA_IN) ||
                     (paddr == `SMC_ADDR_RESULT) || (paddr == `SMC_ADDR_STATUS);
    assign sel     = smc_pkg::reg_sel_t'(paddr[3:2]);
    assign wr_acc  = access & pwrite & addr_ok;
    assign rd_acc  = access & ~pwrite & addr_ok;

    assign data_wr   = wr_acc && (sel == smc_pkg::REG_DATA_IN);
    assign result_rd = rd_acc && (sel == smc_pkg::REG_RESULT);
    assign ctrl_wr   = wr_acc && (sel == smc_pkg::REG_CTRL);
    assign ro_write  = wr_acc && ((sel == smc_pkg::REG_RESULT) || (sel == smc_pkg::REG_STATUS));
    // no room for one more sample in flight
    assign refuse    = data_wr & ~space;

    assign start   = data_wr & space;
    assign sample  = pwdata[WIDTH-1:0];
    assign pop     = result_rd & ~empty;
    assign flush   = ctrl_wr & pwdata[`SMC_CTRL_FLUSH_BIT];
    assign op      = op_q;
    assign pready  = 1'b1;
    assign pslverr = (access & ~addr_ok) | refuse | (result_rd & empty) | ro_write;

    //////////////////////////////
    // control state
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q   <= smc_pkg::OP_TC_TO_SM;
            drop_q <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                op_q <= smc_pkg::conv_op_t'(pwdata[`SMC_CTRL_OP_BIT]);
            end
            if (flush) begin
                drop_q <= 1'b0;
            end else if (refuse) begin
                drop_q <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // read mux
    //////////////////////////////
    always_comb begin
        rd_word = '0;
        if (rd_acc) begin
            case (sel)
                smc_pkg::REG_CTRL: begin
                    rd_word[`SMC_CTRL_OP_BIT] = op_q;
                end
                smc_pkg::REG_RESULT: begin
                    rd_word[WIDTH-1:0] = head;
                end
                smc_pkg::REG_STATUS: begin
                    rd_word[`SMC_STAT_COUNT_MSB:`SMC_STAT_COUNT_LSB] = count;
                    rd_word[`SMC_STAT_EMPTY_BIT] = empty;
                    rd_word[`SMC_STAT_FULL_BIT]  = ~space;
                    rd_word[`SMC_STAT_DROP_BIT]  = drop_q;
                end
                // DATA_IN is write-only
                default: rd_word = '0;
            endcase
        end
    end

    assign prdata = rd_word;

endmodule

// File: hw/smc_pkg.sv
// types shared by the converter and its testbench; encodings match the CTRL bit and paddr[3:2]
package smc_pkg;

    // conversion direction, one per sample
    typedef enum logic [0:0] {
        OP_TC_TO_SM = 1'b0,
        OP_SM_TO_TC = 1'b1
    } conv_op_t;

    // register select, decoded from paddr[3:2]
    typedef enum logic [1:0] {
        REG_CTRL    = 2'd0,
        REG_DATA_IN = 2'd1,
        REG_RESULT  = 2'd2,
        REG_STATUS  = 2'd3
    } reg_sel_t;

endpackage

// File: hw/smc_consts.svh
// shared sizes and register map; WIDTH must be 2..32, queue depth a power of two up to 8
`ifndef SMC_CONSTS_SVH
`define SMC_CONSTS_SVH

// sample and queue sizing
`define SMC_WIDTH          16
`define SMC_QUEUE_DEPTH    4

// register byte addresses
`define SMC_ADDR_CTRL      8'h00
`define SMC_ADDR_DATA_IN   8'h04
`define SMC_ADDR_RESULT    8'h08
`define SMC_ADDR_STATUS    8'h0C

// CTRL fields
`define SMC_CTRL_FLUSH_BIT 0
`define SMC_CTRL_OP_BIT    1

// STATUS fields
`define SMC_STAT_COUNT_MSB 3
`define SMC_STAT_COUNT_LSB 0
`define SMC_STAT_EMPTY_BIT 4
`define SMC_STAT_FULL_BIT  5
`define SMC_STAT_DROP_BIT  6

`endif
